// ==== irigb_config.svh ====
`ifndef IRIGB_CONFIG_SVH
`define IRIGB_CONFIG_SVH

// --------------------
// UART timing
// --------------------

// Clocks per UART bit
`define CLKS_PER_BIT 8

// --------------------
// IRIG-B slot timing
// --------------------

// Clocks per 10 ms symbol slot, scaled down
`define SLOT_CLKS 40
// High time for '0', 2/10 of a slot
`define PULSE_ZERO_CLKS 8
// High time for '1', 5/10 of a slot
`define PULSE_ONE_CLKS 20
// High time for 'P', 8/10 of a slot
`define PULSE_MARK_CLKS 32

// Symbols in one frame
`define FRAME_SYMBOLS 100
// Frame timeout, counted from the first byte
`define FRAME_WINDOW_CLKS 12000

`endif

// ==== uart_pkg.sv ====
package uart_pkg;

	// One received data byte
	typedef logic [7:0] byte_t;

	// Bit position within a character
	typedef logic [3:0] bit_cnt_t;

	// Clocks within one bit
	typedef logic [7:0] baud_cnt_t;

	// Receiver FSM
	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} rx_state_t;

endpackage

// ==== irigb_pkg.sv ====
package irigb_pkg;

	// --------------------
	// Symbol codes, ASCII
	// --------------------
	parameter logic [7:0] SYM_ZERO = 8'h30;
	parameter logic [7:0] SYM_ONE  = 8'h31;
	parameter logic [7:0] SYM_MARK = 8'h50;

	// --------------------
	// Counters
	// --------------------

	// Symbol position within a frame, 0..99
	typedef logic [6:0] sym_index_t;

	// Clock within a slot
	typedef logic [5:0] slot_cnt_t;

	// Pulse width in clocks
	typedef logic [5:0] pulse_clks_t;

	// Frame window, up to 16k clocks
	typedef logic [13:0] window_cnt_t;

	// Playback FSM
	typedef enum logic {
		IDLE,
		PLAY
	} play_state_t;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`include "irigb_config.svh"

module uart_rx (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            rxd,
	output uart_pkg::byte_t byte_data,
	output logic            byte_valid
);
	import uart_pkg::*;

	// Middle of the start bit, seen from the falling edge
	localparam baud_cnt_t HALF_LAST = baud_cnt_t'(`CLKS_PER_BIT / 2 - 1);
	// One full bit from one middle to the next
	localparam baud_cnt_t BIT_LAST  = baud_cnt_t'(`CLKS_PER_BIT - 1);
	localparam bit_cnt_t  DATA_LAST = bit_cnt_t'(7);

	logic      rxd_meta;
	logic      rxd_sync;
	rx_state_t state;
	baud_cnt_t baud_cnt;
	bit_cnt_t  bit_cnt;
	logic      stop_err;

	// Two-stage synchroniser, idles high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	// --------------------
	// Receiver FSM
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			baud_cnt   <= '0;
			bit_cnt    <= '0;
			stop_err   <= 1'b0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			case (state)
				IDLE: begin
					baud_cnt <= '0;
					bit_cnt  <= '0;
					// Falling edge starts a character
					if (!rxd_sync)
						state <= START;
				end
				START: begin
					if (baud_cnt == HALF_LAST) begin
						baud_cnt <= '0;
						// Line back high at mid-bit, treat as a glitch
						state    <= rxd_sync ? IDLE : DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				DATA: begin
					if (baud_cnt == BIT_LAST) begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == DATA_LAST)
							state <= STOP;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				STOP: begin
					if (stop_err) begin
						// Framing error, hold off until the line idles
						if (rxd_sync) begin
							stop_err <= 1'b0;
							state    <= IDLE;
						end
					end else if (baud_cnt == BIT_LAST) begin
						baud_cnt <= '0;
						if (rxd_sync) begin
							byte_valid <= 1'b1;
							state      <= IDLE;
						end else begin
							stop_err <= 1'b1;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Data shift, LSB first, sampled at mid-bit
	always_ff @(posedge clk) begin
		if (state == DATA && baud_cnt == BIT_LAST)
			byte_data <= {rxd_sync, byte_data[7:1]};
	end

endmodule

// ==== symbol_frame_buffer.sv ====
`timescale 1ns/1ps
`include "irigb_config.svh"

module symbol_frame_buffer (
	input  logic            clk,
	input  logic            rst_n,
	input  uart_pkg::byte_t byte_data,
	input  logic            byte_valid,
	output uart_pkg::byte_t sym_data,
	output logic            sym_strobe
);
	import irigb_pkg::*;

	localparam sym_index_t  SYM_LAST    = sym_index_t'(`FRAME_SYMBOLS - 1);
	localparam slot_cnt_t   SLOT_LAST   = slot_cnt_t'(`SLOT_CLKS - 1);
	localparam window_cnt_t WINDOW_LAST = window_cnt_t'(`FRAME_WINDOW_CLKS - 1);

	// One frame of symbol codes
	uart_pkg::byte_t frame_mem [`FRAME_SYMBOLS];

	// Collection side
	sym_index_t  wr_idx;
	logic        window_active;
	window_cnt_t window_cnt;
	logic        window_expired;
	logic        frame_last;
	logic        frame_done;

	// Playback side
	play_state_t state;
	sym_index_t  rd_idx;
	sym_index_t  rd_next;
	slot_cnt_t   slot_cnt;
	logic        slot_end;
	logic        load_sym;
	sym_index_t  load_idx;

	// --------------------
	// Collection
	// --------------------

	// 100th byte of the frame on this strobe
	assign frame_last     = byte_valid && (wr_idx == SYM_LAST);
	assign window_expired = window_active && (window_cnt >= WINDOW_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_idx        <= '0;
			window_active <= 1'b0;
			window_cnt    <= '0;
			frame_done    <= 1'b0;
		end else begin
			// Completion registered one cycle
			frame_done <= frame_last;
			if (byte_valid) begin
				if (frame_last) begin
					// Frame complete, window restarts with the next frame
					wr_idx        <= '0;
					window_active <= 1'b0;
					window_cnt    <= '0;
				end else begin
					wr_idx <= wr_idx + 1'b1;
					if (wr_idx == '0) begin
						// First byte opens the window
						window_active <= 1'b1;
						window_cnt    <= '0;
					end else begin
						window_cnt <= window_cnt + 1'b1;
					end
				end
			end else if (window_expired) begin
				// Timeout, drop the partial frame
				wr_idx        <= '0;
				window_active <= 1'b0;
				window_cnt    <= '0;
			end else if (window_active) begin
				window_cnt <= window_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid)
			frame_mem[wr_idx] <= byte_data;
	end

	// --------------------
	// Playback
	// --------------------

	assign rd_next  = rd_idx + 1'b1;
	assign slot_end = (state == PLAY) && (slot_cnt == SLOT_LAST);
	// New slot: frame start, or end of a slot that is not the last
	assign load_sym = frame_done || (slot_end && rd_idx != SYM_LAST);
	assign load_idx = frame_done ? sym_index_t'(0) : rd_next;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			rd_idx     <= '0;
			slot_cnt   <= '0;
			sym_strobe <= 1'b0;
		end else begin
			sym_strobe <= load_sym;
			if (frame_done) begin
				// Also restarts a playback in progress
				state    <= PLAY;
				rd_idx   <= '0;
				slot_cnt <= '0;
			end else if (state == PLAY) begin
				if (slot_end) begin
					slot_cnt <= '0;
					if (rd_idx == SYM_LAST)
						state <= IDLE;
					else
						rd_idx <= rd_next;
				end else begin
					slot_cnt <= slot_cnt + 1'b1;
				end
			end
		end
	end

	// Symbol code valid alongside sym_strobe
	always_ff @(posedge clk) begin
		if (load_sym)
			sym_data <= frame_mem[load_idx];
	end

endmodule

// ==== irigb_pulse_encoder.sv ====
`timescale 1ns/1ps
`include "irigb_config.svh"

module irigb_pulse_encoder (
	input  logic            clk,
	input  logic            rst_n,
	input  uart_pkg::byte_t sym_data,
	input  logic            sym_strobe,
	output logic            irig_b
);
	import irigb_pkg::*;

	localparam pulse_clks_t ZERO_W = pulse_clks_t'(`PULSE_ZERO_CLKS);
	localparam pulse_clks_t ONE_W  = pulse_clks_t'(`PULSE_ONE_CLKS);
	localparam pulse_clks_t MARK_W = pulse_clks_t'(`PULSE_MARK_CLKS);

	pulse_clks_t width;
	// High cycles left, current one included
	pulse_clks_t pulse_cnt;

	// --------------------
	// Symbol decode
	// --------------------
	always_comb begin
		case (sym_data)
			SYM_ZERO: width = ZERO_W;
			SYM_ONE:  width = ONE_W;
			SYM_MARK: width = MARK_W;
			// Unknown code, slot stays low
			default:  width = '0;
		endcase
	end

	// --------------------
	// Pulse timer
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pulse_cnt <= '0;
			irig_b    <= 1'b0;
		end else if (sym_strobe) begin
			// Rising edge on the cycle after the strobe
			pulse_cnt <= width;
			irig_b    <= (width != '0);
		end else if (pulse_cnt != '0) begin
			pulse_cnt <= pulse_cnt - 1'b1;
			// Drop after the last counted cycle
			irig_b    <= (pulse_cnt > pulse_clks_t'(1));
		end else begin
			irig_b <= 1'b0;
		end
	end

endmodule

// ==== irigb_gen_top.sv ====
`timescale 1ns/1ps

module irigb_gen_top (
	input  logic clk,
	input  logic rst_n,
	input  logic rxd,
	output logic irig_b
);
	import uart_pkg::*;

	// Receiver to buffer
	byte_t byte_data;
	logic  byte_valid;

	// Buffer to encoder, one strobe per slot
	byte_t sym_data;
	logic  sym_strobe;

	uart_rx uart_rx_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.rxd        (rxd),
		.byte_data  (byte_data),
		.byte_valid (byte_valid)
	);

	symbol_frame_buffer symbol_frame_buffer_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.sym_data   (sym_data),
		.sym_strobe (sym_strobe)
	);

	irigb_pulse_encoder irigb_pulse_encoder_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.sym_data   (sym_data),
		.sym_strobe (sym_strobe),
		.irig_b     (irig_b)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held for 16 clocks, released just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		#10;
		rst_n = 1'b1;
	end

endmodule

// ==== irigb_gen_top_tb.sv ====
`timescale 1ns/1ps
`include "irigb_config.svh"

module irigb_gen_top_tb;
	import uart_pkg::*;
	import irigb_pkg::*;

	// --------------------
	// Run length
	// --------------------

	// One 8N1 character
	localparam int BYTE_CLKS   = 10 * `CLKS_PER_BIT;
	localparam int IDLE_CLKS   = 2000;
	localparam int PLAY_CLKS   = `FRAME_SYMBOLS * `SLOT_CLKS;
	localparam int SETTLE_CLKS = 3 * `SLOT_CLKS;
	// Worst case frame test, one extra byte plus an idle bit per byte
	localparam int FRAME_TEST_CLKS = (`FRAME_SYMBOLS + 1) * (BYTE_CLKS + `CLKS_PER_BIT)
		+ PLAY_CLKS + SETTLE_CLKS;
	localparam int PARTIAL_CLKS = 40 * BYTE_CLKS + `FRAME_WINDOW_CLKS + `SLOT_CLKS;
	localparam int CYCLE_LIMIT  = 16 + IDLE_CLKS + 4 * FRAME_TEST_CLKS + PARTIAL_CLKS + 2000;
	// Position of the bad byte in the framing test
	localparam int BAD_POS = 37;

	logic clk;
	logic rst_n;
	logic rxd;
	logic irig_b;

	int cycle = 0;
	int value_errors = 0;
	int other_errors = 0;
	logic [31:0] lcg_state = 32'h98b8953c;

	// Monitor records, one entry per pulse
	int pulse_widths[$];
	int rise_cycles[$];
	logic irig_prev = 1'b0;
	int high_len = 0;

	tb_clock_gen tb_clock_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	irigb_gen_top irigb_gen_top_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.rxd    (rxd),
		.irig_b (irig_b)
	);

	// Cycle count and watchdog
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("simulation timed out after %0d cycles", cycle);
			other_errors = other_errors + 1;
			report_and_finish();
		end
	end

	// Pulse monitor, sampled mid-cycle where irig_b is stable
	always @(negedge clk) begin
		if (irig_b === 1'b1) begin
			if (irig_prev !== 1'b1) begin
				rise_cycles.push_back(cycle);
				high_len = 0;
			end
			high_len = high_len + 1;
		end else if (irig_prev === 1'b1) begin
			pulse_widths.push_back(high_len);
		end
		irig_prev = irig_b;
	end

	// --------------------
	// Helpers
	// --------------------

	function automatic byte_t random_symbol();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		// Upper bits, the low ones cycle too fast
		case ((lcg_state >> 16) % 3)
			0: return SYM_ZERO;
			1: return SYM_ONE;
			default: return SYM_MARK;
		endcase
	endfunction

	// Pulse width from the IRIG-B coding rules
	function automatic pulse_clks_t expected_width(input byte_t code);
		case (code)
			SYM_ZERO: return pulse_clks_t'(`PULSE_ZERO_CLKS);
			SYM_ONE:  return pulse_clks_t'(`PULSE_ONE_CLKS);
			SYM_MARK: return pulse_clks_t'(`PULSE_MARK_CLKS);
			default:  return '0;
		endcase
	endfunction

	task clear_monitor();
		pulse_widths.delete();
		rise_cycles.delete();
	endtask

	// One bit time, entered and left 10 ns after an edge
	task drive_bit(input logic level);
		rxd = level;
		repeat (`CLKS_PER_BIT) @(posedge clk);
		#10;
	endtask

	task automatic send_byte(input byte_t data, input bit bad_stop);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(data[i]);
		if (bad_stop) begin
			drive_bit(1'b0);
			// Line idles so the receiver can recover
			drive_bit(1'b1);
		end else begin
			drive_bit(1'b1);
		end
	endtask

	task automatic send_symbols(input byte_t syms[$], input int bad_pos);
		foreach (syms[i])
			send_byte(syms[i], i == bad_pos);
	endtask

	task check_width(input string name, input pulse_clks_t exp, input pulse_clks_t act);
		if (exp !== act) begin
			$display("** Error %s: pulse width expected %0d, actual %0d", name, exp, act);
			value_errors = value_errors + 1;
		end
	endtask

	task check_count(input string name, input sym_index_t exp, input sym_index_t act);
		if (exp !== act) begin
			$display("** Error %s: pulse count expected %0d, actual %0d", name, exp, act);
			value_errors = value_errors + 1;
		end
	endtask

	task check_spacing(input string name, input window_cnt_t exp, input window_cnt_t act);
		if (exp !== act) begin
			$display("** Error %s: edge spacing expected %0d, actual %0d", name, exp, act);
			value_errors = value_errors + 1;
		end
	endtask

	task expect_low(input string name);
		if (irig_b !== 1'b0) begin
			$display("%s: irig_b is not low while idle", name);
			other_errors = other_errors + 1;
		end
	endtask

	// Wait for playback, then compare every pulse with the sent frame
	task automatic finish_frame_check(input string name, input byte_t syms[$]);
		int slots[$];
		pulse_clks_t widths[$];
		int waited;
		int n;
		int k;
		waited = 0;
		foreach (syms[i]) begin
			if (expected_width(syms[i]) != '0) begin
				slots.push_back(i);
				widths.push_back(expected_width(syms[i]));
			end
		end
		while (pulse_widths.size() < widths.size() && waited < PLAY_CLKS + SETTLE_CLKS) begin
			@(posedge clk);
			waited++;
		end
		// Tail, no pulse may follow the frame
		repeat (SETTLE_CLKS) @(posedge clk);
		#10;
		if (pulse_widths.size() < widths.size())
			$display("%s: playback stopped before the last pulse", name);
		check_count(name, sym_index_t'(widths.size()), sym_index_t'(pulse_widths.size()));
		n = (pulse_widths.size() < widths.size()) ? pulse_widths.size() : widths.size();
		for (k = 0; k < n; k++)
			check_width(name, widths[k], pulse_clks_t'(pulse_widths[k]));
		n = (rise_cycles.size() < slots.size()) ? rise_cycles.size() : slots.size();
		// Edges sit one slot apart per symbol in between
		for (k = 1; k < n; k++)
			check_spacing(name, window_cnt_t'((slots[k] - slots[k - 1]) * `SLOT_CLKS),
				window_cnt_t'(rise_cycles[k] - rise_cycles[k - 1]));
		expect_low(name);
	endtask

	// --------------------
	// Directed tests
	// --------------------

	task automatic test_reset_idle();
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			expect_low("test_reset_idle");
		end
		@(posedge clk);
		#10;
		clear_monitor();
		repeat (IDLE_CLKS) @(posedge clk);
		#10;
		check_count("test_reset_idle", '0, sym_index_t'(rise_cycles.size()));
		expect_low("test_reset_idle");
	endtask

	task automatic test_full_frame();
		byte_t syms[$];
		int i;
		clear_monitor();
		for (i = 0; i < `FRAME_SYMBOLS; i++)
			syms.push_back(random_symbol());
		send_symbols(syms, -1);
		finish_frame_check("test_full_frame", syms);
	endtask

	task automatic test_invalid_code();
		byte_t syms[$];
		int i;
		clear_monitor();
		for (i = 0; i < `FRAME_SYMBOLS; i++)
			syms.push_back(random_symbol());
		// ASCII 'X', no valid code
		syms[50] = 8'h58;
		send_symbols(syms, -1);
		finish_frame_check("test_invalid_code", syms);
	endtask

	task automatic test_frame_timeout();
		byte_t partial[$];
		byte_t syms[$];
		int i;
		clear_monitor();
		for (i = 0; i < 40; i++)
			partial.push_back(SYM_MARK);
		send_symbols(partial, -1);
		repeat (`FRAME_WINDOW_CLKS + `SLOT_CLKS) @(posedge clk);
		#10;
		check_count("test_frame_timeout", '0, sym_index_t'(rise_cycles.size()));
		// Fresh frame must not pick up the dropped bytes
		for (i = 0; i < `FRAME_SYMBOLS; i++)
			syms.push_back(random_symbol());
		send_symbols(syms, -1);
		finish_frame_check("test_frame_timeout", syms);
	endtask

	task automatic test_framing_error();
		byte_t sent[$];
		byte_t good[$];
		byte_t s;
		int i;
		clear_monitor();
		for (i = 0; i <= `FRAME_SYMBOLS; i++) begin
			s = random_symbol();
			sent.push_back(s);
			if (i != BAD_POS)
				good.push_back(s);
		end
		send_symbols(sent, BAD_POS);
		finish_frame_check("test_framing_error", good);
	endtask

	task report_and_finish();
		$display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	initial begin
		rxd = 1'b1;
		test_reset_idle();
		test_full_frame();
		test_invalid_code();
		test_frame_timeout();
		test_framing_error();
		report_and_finish();
	end

endmodule

// ==== irigb_gen_top.f ====
+incdir+.
uart_pkg.sv
irigb_pkg.sv
uart_rx.sv
symbol_frame_buffer.sv
irigb_pulse_encoder.sv
irigb_gen_top.sv
tb_clock_gen.sv
irigb_gen_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the IRIG-B generator testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module irigb_gen_top_tb \
	-f irigb_gen_top.f \
	-o irigb_gen_top_sim

./obj_dir/irigb_gen_top_sim | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"
